//--- sim.f
design/bridge_pkg.sv
design/bridge_ifs.sv
design/crc8_calc.sv
design/frame_parser.sv
design/frame_executor.sv
design/bus_arbiter.sv
design/word_memory.sv
design/bridge_top.sv
testbench/tb_clock_gen.sv
testbench/tb_bridge.sv

//--- Bender.yml
package:
  name: byte_bridge

sources:
  - design/bridge_pkg.sv
  - design/bridge_ifs.sv
  - design/crc8_calc.sv
  - design/frame_parser.sv
  - design/frame_executor.sv
  - design/bus_arbiter.sv
  - design/word_memory.sv
  - design/bridge_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_bridge.sv

//--- testbench/tb_bridge.sv
module tb_bridge;

    localparam logic [31:0] SEED         = 32'hf684_4f21;
    localparam int          RESP_TIMEOUT = 2000;
    localparam int          ACK_TIMEOUT  = 60;

    logic              clk;
    logic              rst;
    bridge_pkg::byte_t rx_data  = 8'h00;
    logic              rx_empty = 1'b1;
    logic              rx_rd_en;
    bridge_pkg::byte_t tx_data;
    logic              tx_full  = 1'b0;
    logic              tx_wr_en;
    logic              loc_req;
    logic              loc_we;
    bridge_pkg::widx_t loc_addr;
    bridge_pkg::be_t   loc_be;
    bridge_pkg::word_t loc_wdata;
    bridge_pkg::word_t loc_rdata;
    logic              loc_ack;

    bridge_pkg::byte_t rx_q [$];        // Every byte ever offered to the receive FIFO
    int                rx_idx = 0;      // Head of the receive FIFO
    bridge_pkg::byte_t exp_bytes [$];   // Expected transmit stream
    int                exp_idx = 0;
    bridge_pkg::byte_t wr_data [$];
    bridge_pkg::byte_t no_data [$];
    bridge_pkg::word_t model [bridge_pkg::MEM_WORDS];
    logic [31:0]       frame_rng = SEED;
    logic [31:0]       loc_rng   = SEED ^ 32'h3c3c_a5a5;
    logic [31:0]       tx_rng    = SEED ^ 32'h5555_aaaa;
    int                tx_errors = 0;
    int                errors    = 0;
    int                timeouts  = 0;
    logic              popped;

    tb_clock_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    bridge_top dut (
        .clk       (clk),
        .rst       (rst),
        .rx_data   (rx_data),
        .rx_empty  (rx_empty),
        .rx_rd_en  (rx_rd_en),
        .tx_data   (tx_data),
        .tx_full   (tx_full),
        .tx_wr_en  (tx_wr_en),
        .loc_req   (loc_req),
        .loc_we    (loc_we),
        .loc_addr  (loc_addr),
        .loc_be    (loc_be),
        .loc_wdata (loc_wdata),
        .loc_rdata (loc_rdata),
        .loc_ack   (loc_ack)
    );

    function automatic logic [31:0] lcg_next(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    // Upper LCG bits are the better ones
    function automatic int rand_below(inout logic [31:0] state, input int n);
        logic [31:0] r;
        r = lcg_next(state);
        return int'(r[31:8]) % n;
    endfunction

    // CRC-8 with polynomial 07 and start value 00 taken MSB first
    function automatic bridge_pkg::byte_t crc8(input bridge_pkg::byte_t bytes [$]);
        bridge_pkg::byte_t c;
        c = 8'h00;
        foreach (bytes[i]) begin
            c = c ^ bytes[i];
            for (int k = 0; k < 8; k++) begin
                c = c[7] ? ((c << 1) ^ 8'h07) : (c << 1);
            end
        end
        return c;
    endfunction

    // Start value of each memory word from every bit of its index
    function automatic bridge_pkg::word_t fill_word(input int idx);
        return (idx * 32'h0101_0101) ^ 32'ha5c3_0f69 ^ (idx << 20);
    endfunction

    // Frames stay below word 200 and the random upper bits test the wrap
    function automatic bridge_pkg::addr_t random_addr(input int sz);
        bridge_pkg::addr_t a;
        a      = lcg_next(frame_rng);
        a[9:0] = 10'(rand_below(frame_rng, 180) * 4);
        if (sz == 0) begin
            a[1:0] = 2'(rand_below(frame_rng, 4));
        end else if (sz == 1) begin
            a[1] = rand_below(frame_rng, 2) == 1;
        end
        return a;
    endfunction

    function automatic void make_data(input int n);
        wr_data.delete();
        for (int i = 0; i < n; i++) begin
            wr_data.push_back(bridge_pkg::byte_t'(rand_below(frame_rng, 256)));
        end
    endfunction

    function automatic bridge_pkg::byte_t expected_status(input bridge_pkg::byte_t cmd,
            input bridge_pkg::addr_t addr, input logic bad_crc, input logic stall);
        if (stall) begin
            return bridge_pkg::STATUS_TIMEOUT;
        end else if (cmd[5:4] == 2'b11) begin
            return bridge_pkg::STATUS_CMD_INV;
        end else if (bad_crc) begin
            return bridge_pkg::STATUS_CRC_ERR;
        end else if (addr % (32'd1 << cmd[5:4]) != 0) begin  // Not a multiple of the size
            return bridge_pkg::STATUS_ADDR_ALIGN;
        end
        return bridge_pkg::STATUS_OK;
    endfunction

    // Applies a frame to the model and queues its response bytes
    function automatic void build_response(input bridge_pkg::byte_t cmd,
            input bridge_pkg::addr_t addr, input bridge_pkg::byte_t data [$],
            input bridge_pkg::byte_t status);
        bridge_pkg::byte_t body [$];
        bridge_pkg::addr_t a;
        bridge_pkg::widx_t w;
        int                esz;
        int                lane;
        body.push_back(status);
        body.push_back(cmd);
        esz = 1 << cmd[5:4];
        a   = addr;
        if (status == bridge_pkg::STATUS_OK) begin
            for (int i = 0; i <= int'(cmd[3:0]); i++) begin
                w    = a[9:2];      // 1 KiB wrap
                lane = int'(a[1:0]);
                for (int b = 0; b < esz; b++) begin
                    if (cmd[7]) begin
                        body.push_back(model[w][8*(lane+b) +: 8]);
                    end else begin
                        model[w][8*(lane+b) +: 8] = data[i*esz+b];
                    end
                end
                if (cmd[6]) begin
                    a = a + esz;
                end
            end
        end
        exp_bytes.push_back(bridge_pkg::SOF_D2H);
        foreach (body[k]) begin
            exp_bytes.push_back(body[k]);
        end
        exp_bytes.push_back(crc8(body));
    endfunction

    // One access on the local port held until ack
    task automatic local_access(input logic we, input bridge_pkg::widx_t w,
            input bridge_pkg::be_t be, input bridge_pkg::word_t d);
        bridge_pkg::word_t expect_word;
        int                t;
        expect_word = model[w];
        @(negedge clk);
        loc_req   = 1'b1;
        loc_we    = we;
        loc_addr  = w;
        loc_be    = be;
        loc_wdata = d;
        t = 0;
        while (loc_ack !== 1'b1 && t < ACK_TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        loc_req = 1'b0;
        if (loc_ack !== 1'b1) begin
            timeouts++;
            $display("Local access to word %0d was never acknowledged", w);
        end else if (!we) begin
            if (loc_rdata !== expect_word) begin
                errors++;
                $display("error at time %0t: loc_rdata expected %08h, got %08h",
                         $time, expect_word, loc_rdata);
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    model[w][8*b +: 8] = d[8*b +: 8];
                end
            end
        end
    endtask

    // Local traffic on words 200 to 255 out of reach of the frames
    task automatic local_traffic(input int n);
        logic [31:0]       r;
        bridge_pkg::widx_t w;
        int                gap;
        for (int i = 0; i < n; i++) begin
            gap = rand_below(loc_rng, 48);
            repeat (gap) @(negedge clk);
            r = lcg_next(loc_rng);
            w = bridge_pkg::widx_t'(200 + rand_below(loc_rng, 56));
            local_access(r[20], w, r[11:8], lcg_next(loc_rng));
        end
    endtask

    task automatic run_frame(input bridge_pkg::byte_t cmd, input bridge_pkg::addr_t addr,
            input bridge_pkg::byte_t data [$], input logic bad_crc, input logic stall,
            input int garbage);
        bridge_pkg::byte_t body [$];
        bridge_pkg::byte_t crc;
        bridge_pkg::byte_t junk;
        int                t;
        build_response(cmd, addr, data, expected_status(cmd, addr, bad_crc, stall));
        body.push_back(cmd);
        for (int k = 0; k < 4; k++) begin
            body.push_back(addr[8*k +: 8]);     // LSB first
        end
        foreach (data[k]) begin
            body.push_back(data[k]);
        end
        crc = crc8(body) ^ (bad_crc ? 8'h3c : 8'h00);
        @(posedge clk);
        repeat (garbage) begin
            junk = bridge_pkg::byte_t'(rand_below(frame_rng, 256));
            if (junk == bridge_pkg::SOF_H2D) begin
                junk = 8'hff;
            end
            rx_q.push_back(junk);
        end
        rx_q.push_back(bridge_pkg::SOF_H2D);
        foreach (body[k]) begin
            if (!stall || k < 5) begin
                rx_q.push_back(body[k]);
            end
        end
        if (!stall) begin
            rx_q.push_back(crc);
        end
        t = 0;
        while (exp_idx < exp_bytes.size() && t < RESP_TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (exp_idx < exp_bytes.size()) begin
            timeouts++;
            $display("Response to command %02h at address %08h did not complete", cmd, addr);
        end
    endtask

    // Receive FIFO with its head byte on rx_data
    always begin
        @(posedge clk);
        popped = rx_rd_en && !rx_empty;
        @(negedge clk);
        if (popped) begin
            rx_idx++;
        end
        rx_empty = (rx_idx >= rx_q.size());
        rx_data  = rx_empty ? 8'h00 : rx_q[rx_idx];
    end

    always @(negedge clk) begin
        tx_full = !rst && (rand_below(tx_rng, 4) == 0);    // Random back-pressure
    end

    // Compares every transmitted byte
    always @(posedge clk) begin
        if (!rst && tx_wr_en) begin
            if (tx_full) begin
                tx_errors++;
                $display("Transmit write while the FIFO was full at time %0t", $time);
            end
            if (exp_idx >= exp_bytes.size()) begin
                tx_errors++;
                $display("Unexpected transmit byte %02h at time %0t", tx_data, $time);
            end else begin
                if (tx_data !== exp_bytes[exp_idx]) begin
                    tx_errors++;
                    $display("error at time %0t: tx_data expected %02h, got %02h",
                             $time, exp_bytes[exp_idx], tx_data);
                end
                exp_idx++;
            end
        end
    end

    initial begin
        bridge_pkg::addr_t addr;
        bridge_pkg::byte_t cmd;
        int                t;
        loc_req   = 1'b0;
        loc_we    = 1'b0;
        loc_addr  = '0;
        loc_be    = '0;
        loc_wdata = '0;
        t = 0;
        while (rst !== 1'b0 && t < 20) begin
            @(negedge clk);
            t++;
        end
        if (rst !== 1'b0) begin
            timeouts++;
            $display("Reset was never released");
        end

        // Known contents in every word
        for (int i = 0; i < bridge_pkg::MEM_WORDS; i++) begin
            local_access(1'b1, bridge_pkg::widx_t'(i), 4'hf, fill_word(i));
        end

        fork
            local_traffic(500);
            begin
                // Write and read back each size, count and increment setting
                for (int sz = 0; sz < 3; sz++) begin
                    for (int cnt = 0; cnt < 16; cnt++) begin
                        for (int inc = 0; inc < 2; inc++) begin
                            addr = random_addr(sz);
                            cmd  = {1'b0, inc[0], sz[1:0], cnt[3:0]};
                            make_data((cnt + 1) << sz);
                            run_frame(cmd, addr, wr_data, 1'b0, 1'b0, 0);
                            run_frame(cmd | 8'h80, addr, no_data, 1'b0, 1'b0, 0);
                        end
                    end
                end

                // Bad CRC, then read back
                make_data(16);
                run_frame(8'h63, 32'h0000_0200, wr_data, 1'b1, 1'b0, 0);
                run_frame(8'he3, 32'h0000_0200, no_data, 1'b0, 1'b0, 0);

                // Size 11 and misaligned accesses
                run_frame(8'h30, 32'h0000_0100, no_data, 1'b0, 1'b0, 0);
                run_frame(8'he0, 32'h0000_0100, no_data, 1'b0, 1'b0, 0);
                make_data(4);
                run_frame(8'h51, 32'h0000_0051, wr_data, 1'b0, 1'b0, 0);
                run_frame(8'he1, 32'h0000_0050, no_data, 1'b0, 1'b0, 0);
                run_frame(8'h60, 32'h0000_0062, wr_data, 1'b0, 1'b0, 0);
                run_frame(8'he0, 32'h0000_0060, no_data, 1'b0, 1'b0, 0);

                // Stall after the address, then garbage before a good frame
                run_frame(8'he3, 32'h0000_0040, no_data, 1'b0, 1'b1, 0);
                run_frame(8'he3, 32'h0000_0040, no_data, 1'b0, 1'b0, 5);
            end
        join

        if (rx_idx != rx_q.size()) begin
            errors++;
            $display("%0d receive bytes were never read by the bridge", rx_q.size() - rx_idx);
        end
        $display("Counts: %0d transmit errors, %0d other errors, %0d timeouts",
                 tx_errors, errors, timeouts);
        if (tx_errors + errors + timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- testbench/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;     // Period of 20
        end
    end

    // Reset held for three rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- design/bridge_top.sv
module bridge_top (
    input  logic              clk,
    input  logic              rst,
    input  bridge_pkg::byte_t rx_data,
    input  logic              rx_empty,
    output logic              rx_rd_en,
    output bridge_pkg::byte_t tx_data,
    input  logic              tx_full,
    output logic              tx_wr_en,
    input  logic              loc_req,
    input  logic              loc_we,
    input  bridge_pkg::widx_t loc_addr,
    input  bridge_pkg::be_t   loc_be,
    input  bridge_pkg::word_t loc_wdata,
    output bridge_pkg::word_t loc_rdata,
    output logic              loc_ack
);
    frame_if   frm ();
    mem_bus_if exe_bus ();
    mem_bus_if loc_bus ();
    mem_bus_if mem_bus ();

    // Local port as the second bus master
    assign loc_bus.req   = loc_req;
    assign loc_bus.we    = loc_we;
    assign loc_bus.widx  = loc_addr;
    assign loc_bus.be    = loc_be;
    assign loc_bus.wdata = loc_wdata;
    assign loc_rdata     = loc_bus.rdata;
    assign loc_ack       = loc_bus.ack;

    frame_parser u_parser (
        .clk      (clk),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_empty (rx_empty),
        .rx_rd_en (rx_rd_en),
        .frm      (frm.parser)
    );

    frame_executor u_executor (
        .clk      (clk),
        .rst      (rst),
        .frm      (frm.executor),
        .bus      (exe_bus.master),
        .tx_data  (tx_data),
        .tx_full  (tx_full),
        .tx_wr_en (tx_wr_en)
    );

    bus_arbiter u_arbiter (
        .clk (clk),
        .rst (rst),
        .m0  (exe_bus.slave),
        .m1  (loc_bus.slave),
        .s   (mem_bus.master)
    );

    word_memory u_memory (
        .clk (clk),
        .rst (rst),
        .bus (mem_bus.slave)
    );

endmodule

//--- design/word_memory.sv
module word_memory (
    input  logic     clk,
    input  logic     rst,
    mem_bus_if.slave bus
);
    bridge_pkg::word_t mem [bridge_pkg::MEM_WORDS];
    logic              access;

    assign access = bus.req && !bus.ack;    // One access per held req

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            bus.rdata <= mem[bus.widx];
            for (int b = 0; b < 4; b++) begin
                if (bus.we && bus.be[b]) begin
                    mem[bus.widx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- design/bus_arbiter.sv
module bus_arbiter (
    input  logic      clk,
    input  logic      rst,
    mem_bus_if.slave  m0,
    mem_bus_if.slave  m1,
    mem_bus_if.master s
);
    logic busy;     // Grant held until ack
    logic sel;      // Granted master
    logic prio;     // m1 wins a tie when set

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            sel  <= 1'b0;
            prio <= 1'b0;
        end else if (!busy) begin
            if (m0.req || m1.req) begin
                busy <= 1'b1;
                sel  <= m1.req && (!m0.req || prio);
            end
        end else if (s.ack) begin
            busy <= 1'b0;
            prio <= !sel;   // Other master goes first next time
        end
    end

    assign s.req   = busy && (sel ? m1.req : m0.req);
    assign s.we    = sel ? m1.we : m0.we;
    assign s.widx  = sel ? m1.widx : m0.widx;
    assign s.be    = sel ? m1.be : m0.be;
    assign s.wdata = sel ? m1.wdata : m0.wdata;

    assign m0.ack   = s.ack && !sel;
    assign m1.ack   = s.ack && sel;
    assign m0.rdata = sel ? '0 : s.rdata;
    assign m1.rdata = sel ? s.rdata : '0;

endmodule

//--- design/frame_executor.sv
module frame_executor (
    input  logic              clk,
    input  logic              rst,
    frame_if.executor         frm,
    mem_bus_if.master         bus,
    output bridge_pkg::byte_t tx_data,
    input  logic              tx_full,
    output logic              tx_wr_en
);
    typedef enum logic [2:0] {
        E_IDLE,
        E_HDR,      // A5, status, command echo
        E_LOAD,     // Gather write bytes of one element
        E_ACC,
        E_DATA,     // Send read bytes of one element
        E_CRC
    } exec_state_t;

    exec_state_t       state;
    logic [1:0]        hcnt;
    logic [1:0]        bcnt;
    logic [1:0]        lane;
    logic [2:0]        esz;
    bridge_pkg::dcnt_t boff;
    bridge_pkg::addr_t addr_q;
    bridge_pkg::word_t word_q;
    bridge_pkg::byte_t status_q;
    bridge_pkg::byte_t crc;
    logic              skip;
    logic              is_wr;
    logic              misaligned;
    logic              elem_done;
    logic              last_elem;

    assign is_wr      = !frm.cmd[7];
    assign esz        = 3'd1 << frm.cmd[5:4];
    assign lane       = addr_q[1:0] + bcnt;
    assign last_elem  = (boff + esz == frm.data_count);
    assign misaligned = (frm.cmd[5:4] == 2'b01 && frm.addr[0]) ||
                        (frm.cmd[5:4] == 2'b10 && frm.addr[1:0] != 2'b00);
    assign elem_done  = is_wr ? (state == E_ACC && bus.ack)
                              : (state == E_DATA && tx_wr_en && bcnt == esz - 1'b1);

    assign frm.data_idx       = boff[5:0] + bcnt;
    assign frm.frame_consumed = tx_wr_en && state == E_CRC;  // With the last byte

    assign tx_wr_en = !tx_full && state inside {E_HDR, E_DATA, E_CRC};

    always_comb begin
        if (state == E_DATA) begin
            tx_data = word_q[8*lane +: 8];
        end else if (state == E_CRC) begin
            tx_data = crc;
        end else if (hcnt == 2'd0) begin
            tx_data = bridge_pkg::SOF_D2H;
        end else if (hcnt == 2'd1) begin
            tx_data = status_q;
        end else begin
            tx_data = frm.cmd;
        end
    end

    // CRC covers everything between SOF and the CRC byte
    crc8_calc u_crc (
        .clk     (clk),
        .rst     (rst),
        .clear   (state == E_IDLE),
        .enable  (tx_wr_en && state != E_CRC && !(state == E_HDR && hcnt == 2'd0)),
        .data_in (tx_data),
        .crc     (crc)
    );

    assign bus.we    = is_wr;
    assign bus.widx  = addr_q[9:2];     // Wraps at 1 KiB
    assign bus.wdata = word_q;

    always_comb begin
        case (frm.cmd[5:4])
            2'b00:   bus.be = 4'b0001 << addr_q[1:0];
            2'b01:   bus.be = 4'b0011 << addr_q[1:0];
            default: bus.be = 4'b1111;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= E_IDLE;
            hcnt    <= '0;
            bcnt    <= '0;
            bus.req <= 1'b0;
        end else begin
            case (state)
                E_IDLE: if (frm.frame_valid || frm.frame_error) begin
                    status_q <= (frm.frame_valid && misaligned) ?
                                bridge_pkg::STATUS_ADDR_ALIGN : frm.error_status;
                    skip     <= frm.frame_error || misaligned;  // Status-only response
                    addr_q   <= frm.addr;
                    boff     <= '0;
                    hcnt     <= '0;
                    bcnt     <= '0;
                    state    <= E_HDR;
                end
                E_HDR: if (tx_wr_en) begin
                    hcnt <= hcnt + 1'b1;
                    if (hcnt == 2'd2) begin
                        state <= skip ? E_CRC : (is_wr ? E_LOAD : E_ACC);
                    end
                end
                E_LOAD: begin
                    word_q[8*lane +: 8] <= frm.data_byte;
                    bcnt                <= bcnt + 1'b1;
                    if (bcnt == esz - 1'b1) begin
                        bcnt  <= '0;
                        state <= E_ACC;
                    end
                end
                E_ACC: begin
                    bus.req <= !bus.ack;    // Low for the cycle after ack
                    if (bus.ack && !is_wr) begin
                        word_q <= bus.rdata;
                        state  <= E_DATA;
                    end
                end
                E_DATA: if (tx_wr_en) begin
                    bcnt <= bcnt + 1'b1;
                    if (bcnt == esz - 1'b1) begin
                        bcnt <= '0;
                    end
                end
                default: begin
                    if (tx_wr_en) begin
                        state <= E_IDLE;
                    end
                end
            endcase

            if (elem_done) begin
                boff <= boff + esz;
                if (frm.cmd[6]) begin
                    addr_q <= addr_q + esz;
                end
                if (last_elem) begin
                    state <= E_CRC;
                end else begin
                    state <= is_wr ? E_LOAD : E_ACC;
                end
            end
        end
    end

endmodule

//--- design/frame_parser.sv
module frame_parser (
    input  logic              clk,
    input  logic              rst,
    input  bridge_pkg::byte_t rx_data,
    input  logic              rx_empty,
    output logic              rx_rd_en,
    frame_if.parser           frm
);
    bridge_pkg::parser_state_t state;
    bridge_pkg::byte_t         buf_mem [bridge_pkg::MAX_DATA_BYTES];
    bridge_pkg::dcnt_t         buf_cnt;
    bridge_pkg::dcnt_t         xfer_bytes;
    bridge_pkg::byte_t         crc;
    logic [$clog2(bridge_pkg::TIMEOUT_CLOCKS)-1:0] tmo_cnt;
    logic                      in_frame;
    logic                      cmd_inv;

    assign in_frame = state inside {[bridge_pkg::CMD : bridge_pkg::CRC]};
    assign rx_rd_en = !rx_empty && (in_frame || state == bridge_pkg::IDLE);
    assign frm.data_byte = buf_mem[frm.data_idx];

    // Byte count of the transfer, taken from the command byte on the bus
    always_comb begin
        xfer_bytes = (7'(rx_data[3:0]) + 7'd1) << rx_data[5:4];
        if (rx_data[5:4] == 2'b11) begin
            xfer_bytes = '0;
        end
    end

    crc8_calc u_crc (
        .clk     (clk),
        .rst     (rst),
        .clear   (state == bridge_pkg::IDLE),
        .enable  (rx_rd_en && in_frame && state != bridge_pkg::CRC),
        .data_in (rx_data),
        .crc     (crc)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= bridge_pkg::IDLE;
            buf_cnt         <= '0;
            tmo_cnt         <= '0;
            cmd_inv         <= 1'b0;
            frm.frame_valid <= 1'b0;
            frm.frame_error <= 1'b0;
        end else begin
            if (rx_rd_en || !in_frame) begin
                tmo_cnt <= '0;
            end else begin
                tmo_cnt <= tmo_cnt + 1'b1;  // Empty cycle inside a frame
            end

            case (state)
                bridge_pkg::IDLE: begin
                    buf_cnt <= '0;
                    if (rx_rd_en && rx_data == bridge_pkg::SOF_H2D) begin
                        state <= bridge_pkg::CMD;
                    end
                end
                bridge_pkg::CMD: if (rx_rd_en) begin
                    frm.cmd        <= rx_data;
                    frm.data_count <= xfer_bytes;
                    cmd_inv        <= (rx_data[5:4] == 2'b11);
                    state          <= bridge_pkg::ADDR0;
                end
                bridge_pkg::ADDR0: if (rx_rd_en) begin
                    frm.addr[7:0] <= rx_data;
                    state         <= bridge_pkg::ADDR1;
                end
                bridge_pkg::ADDR1: if (rx_rd_en) begin
                    frm.addr[15:8] <= rx_data;
                    state          <= bridge_pkg::ADDR2;
                end
                bridge_pkg::ADDR2: if (rx_rd_en) begin
                    frm.addr[23:16] <= rx_data;
                    state           <= bridge_pkg::ADDR3;
                end
                bridge_pkg::ADDR3: if (rx_rd_en) begin
                    frm.addr[31:24] <= rx_data;
                    // Reads and invalid sizes carry no data
                    if (frm.cmd[7] || frm.data_count == '0) begin
                        state <= bridge_pkg::CRC;
                    end else begin
                        state <= bridge_pkg::DATA;
                    end
                end
                bridge_pkg::DATA: if (rx_rd_en) begin
                    buf_cnt <= buf_cnt + 1'b1;
                    if (buf_cnt + 1'b1 == frm.data_count) begin
                        state <= bridge_pkg::CRC;
                    end
                end
                bridge_pkg::CRC: if (rx_rd_en) begin
                    if (cmd_inv) begin
                        frm.error_status <= bridge_pkg::STATUS_CMD_INV;
                    end else if (rx_data != crc) begin
                        frm.error_status <= bridge_pkg::STATUS_CRC_ERR;
                    end else begin
                        frm.error_status <= bridge_pkg::STATUS_OK;
                    end
                    state <= bridge_pkg::DONE;
                end
                default: begin  // DONE or ABORT
                    if (frm.frame_consumed) begin
                        state <= bridge_pkg::IDLE;
                    end
                end
            endcase

            if (in_frame && !rx_rd_en && tmo_cnt == bridge_pkg::TIMEOUT_CLOCKS - 1) begin
                state            <= bridge_pkg::ABORT;
                frm.error_status <= bridge_pkg::STATUS_TIMEOUT;
            end

            // Result levels held until the executor is done
            if (frm.frame_consumed) begin
                frm.frame_valid <= 1'b0;
                frm.frame_error <= 1'b0;
            end else if (state == bridge_pkg::DONE) begin
                frm.frame_valid <= (frm.error_status == bridge_pkg::STATUS_OK);
                frm.frame_error <= (frm.error_status != bridge_pkg::STATUS_OK);
            end else if (state == bridge_pkg::ABORT) begin
                frm.frame_error <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == bridge_pkg::DATA && rx_rd_en) begin
            buf_mem[buf_cnt[5:0]] <= rx_data;
        end
    end

endmodule

//--- design/crc8_calc.sv
module crc8_calc (
    input  logic              clk,
    input  logic              rst,
    input  logic              clear,
    input  logic              enable,
    input  bridge_pkg::byte_t data_in,
    output bridge_pkg::byte_t crc
);
    bridge_pkg::byte_t crc_next;

    // Polynomial x^8 + x^2 + x + 1, MSB first
    always_comb begin
        crc_next = crc ^ data_in;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[7]) begin
                crc_next = {crc_next[6:0], 1'b0} ^ 8'h07;
            end else begin
                crc_next = {crc_next[6:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            crc <= '0;
        end else if (enable) begin
            crc <= crc_next;
        end
    end

endmodule

//--- design/bridge_ifs.sv
interface frame_if;
    bridge_pkg::byte_t cmd;
    bridge_pkg::addr_t addr;
    bridge_pkg::dcnt_t data_count;      // Bytes moved by the command
    logic              frame_valid;
    logic              frame_error;
    bridge_pkg::byte_t error_status;
    bridge_pkg::byte_t data_byte;       // Buffer entry at data_idx
    bridge_pkg::didx_t data_idx;
    logic              frame_consumed;

    modport parser (output cmd, addr, data_count, frame_valid, frame_error,
                    error_status, data_byte, input data_idx, frame_consumed);
    modport executor (input cmd, addr, data_count, frame_valid, frame_error,
                      error_status, data_byte, output data_idx, frame_consumed);
endinterface

interface mem_bus_if;
    logic              req;
    logic              we;
    bridge_pkg::widx_t widx;
    bridge_pkg::be_t   be;
    bridge_pkg::word_t wdata;
    bridge_pkg::word_t rdata;   // Valid with ack
    logic              ack;

    modport master (output req, we, widx, be, wdata, input rdata, ack);
    modport slave (input req, we, widx, be, wdata, output rdata, ack);
endinterface

//--- design/bridge_pkg.sv
package bridge_pkg;

    typedef logic [7:0]  byte_t;    // One protocol byte
    typedef logic [31:0] addr_t;    // Byte address from the host
    typedef logic [31:0] word_t;
    typedef logic [7:0]  widx_t;    // Word index into memory
    typedef logic [3:0]  be_t;
    typedef logic [6:0]  dcnt_t;    // Payload byte count, 0 to 64
    typedef logic [5:0]  didx_t;    // Data buffer index

    // Start-of-frame bytes
    localparam byte_t SOF_H2D = 8'h5A;
    localparam byte_t SOF_D2H = 8'hA5;

    // Response status codes
    localparam byte_t STATUS_OK         = 8'h00;
    localparam byte_t STATUS_CRC_ERR    = 8'h01;
    localparam byte_t STATUS_CMD_INV    = 8'h02;
    localparam byte_t STATUS_ADDR_ALIGN = 8'h03;
    localparam byte_t STATUS_TIMEOUT    = 8'h04;

    localparam int MAX_DATA_BYTES = 64;     // 16 elements of 32 bits
    localparam int TIMEOUT_CLOCKS = 200;    // Idle clocks inside a frame
    localparam int MEM_WORDS      = 256;

    typedef enum logic [3:0] {
        IDLE,
        CMD,
        ADDR0,
        ADDR1,
        ADDR2,
        ADDR3,
        DATA,
        CRC,
        DONE,
        ABORT
    } parser_state_t;

endpackage
